/* sd_dma_pkg.sv */
package sd_dma_pkg;

   //////////////////////////////
   // Block layout
   //////////////////////////////

   // Data bytes per block
   localparam int block_bytes = 512;

   // Trailing CRC bytes, clocked in and dropped
   localparam int crc_bytes = 2;

   // Everything the card sends for one block
   localparam int total_bytes = block_bytes + crc_bytes;

   // Byte counter covers 0 .. total_bytes
   localparam int byte_cnt_w = $clog2(total_bytes + 1);

   //////////////////////////////
   // Serial clock timing
   //////////////////////////////

   // clk cycles per sck phase
   localparam int sck_half = 2;

   // sck low time before the first bit
   localparam int lead_cycles = 8;

   // sck low time between two bytes
   localparam int byte_gap = 4;

   // Longest count the phase counter has to reach
   localparam int phase_max = (lead_cycles > byte_gap) ?
                              ((lead_cycles > sck_half) ? lead_cycles : sck_half) :
                              ((byte_gap > sck_half) ? byte_gap : sck_half);

   localparam int phase_w = (phase_max > 1) ? $clog2(phase_max) : 1;

   //////////////////////////////
   // Buffer and SRAM
   //////////////////////////////

   localparam int fifo_depth = 4;
   localparam int fifo_ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

   localparam int addr_w = 9;

   // Reader FSM
   typedef enum logic [1:0] {
      st_idle,
      st_lead,
      st_shift,
      st_gap
   } reader_state_e;

   // One byte on its way to the SRAM, last marks byte 511
   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } byte_beat_t;

   // SRAM write port
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [7:0]        data;
      logic              we;
   } sram_wr_t;

endpackage

/* spi_block_reader.sv */
module spi_block_reader
   import sd_dma_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       trig,
   input  logic       miso,
   input  logic       full,
   output logic       sck,
   output logic       busy,
   output logic       push,
   output byte_beat_t push_beat
);

   reader_state_e         state;

   // Input synchronizers
   logic                  trig_s1;
   logic                  trig_s2;
   logic                  trig_d;
   logic                  miso_r;
   logic                  start;

   // Timing and position within the block
   logic [phase_w-1:0]    ph;
   logic                  ph_end;
   logic [2:0]            bit_cnt;
   logic [byte_cnt_w-1:0] byte_cnt;

   // Assembled byte and its push request
   logic [7:0]            shreg;
   logic                  pend;
   logic                  sample;

   //////////////////////////////
   // Trigger and miso capture
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         trig_s1 <= 1'b1;
         trig_s2 <= 1'b1;
         trig_d  <= 1'b1;
         miso_r  <= 1'b1;
      end else begin
         trig_s1 <= trig;
         trig_s2 <= trig_s1;
         trig_d  <= trig_s2;
         miso_r  <= miso;
      end
   end

   // Falling edge, honoured only when idle
   assign start = trig_d & ~trig_s2 & (state == st_idle);

   //////////////////////////////
   // Serial clock FSM
   //////////////////////////////

   assign ph_end = (ph == phase_w'(sck_half - 1));

   // Clock edge that ends an sck high phase
   assign sample = (state == st_shift) & sck & ph_end;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         sck      <= 1'b0;
         ph       <= '0;
         bit_cnt  <= '0;
         byte_cnt <= '0;
         pend     <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               ph <= '0;
               if (start) begin
                  state    <= st_lead;
                  bit_cnt  <= '0;
                  byte_cnt <= '0;
               end
            end
            st_lead: begin
               if (ph == phase_w'(lead_cycles - 1)) begin
                  state <= st_shift;
                  sck   <= 1'b1;
                  ph    <= '0;
               end else begin
                  ph <= ph + 1'b1;
               end
            end
            st_shift: begin
               if (!ph_end) begin
                  ph <= ph + 1'b1;
               end else begin
                  ph  <= '0;
                  sck <= ~sck;
                  if (sck) begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        // CRC bytes are never queued
                        pend     <= (byte_cnt < byte_cnt_w'(block_bytes));
                        state    <= (byte_cnt == byte_cnt_w'(total_bytes - 1)) ?
                                    st_idle : st_gap;
                     end
                  end
               end
            end
            st_gap: begin
               if (push) begin
                  pend <= 1'b0;
               end
               if (ph != phase_w'(byte_gap - 1)) begin
                  ph <= ph + 1'b1;
               end else if (!pend || push) begin
                  // Held here with sck low while the FIFO is full
                  state <= st_shift;
                  sck   <= 1'b1;
                  ph    <= '0;
               end
            end
            default: begin
               state <= st_idle;
               sck   <= 1'b0;
            end
         endcase
      end
   end

   // Shift register, MSB first
   always_ff @(posedge clk) begin
      if (sample) begin
         shreg <= {shreg[6:0], miso_r};
      end
   end

   assign busy = (state != st_idle);

   // Byte stays put in shreg until the next byte starts
   assign push           = (state == st_gap) & pend & ~full;
   assign push_beat.data = shreg;
   assign push_beat.last = (byte_cnt == byte_cnt_w'(block_bytes));

endmodule

/* byte_fifo.sv */
module byte_fifo
   import sd_dma_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       push,
   input  byte_beat_t push_beat,
   input  logic       pop,
   output byte_beat_t pop_beat,
   output logic       full,
   output logic       empty
);

   byte_beat_t            mem [fifo_depth];
   logic [fifo_ptr_w-1:0] wr_ptr;
   logic [fifo_ptr_w-1:0] rd_ptr;
   logic [fifo_cnt_w-1:0] count;
   logic                  do_push;
   logic                  do_pop;

   assign full  = (count == fifo_cnt_w'(fifo_depth));
   assign empty = (count == '0);

   // Overflow and underflow requests are dropped
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign pop_beat = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_beat;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* sram_block_writer.sv */
module sram_block_writer
   import sd_dma_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  byte_beat_t pop_beat,
   input  logic       empty,
   input  logic       sram_busy,
   output logic       pop,
   output sram_wr_t   sram_wr,
   output logic       done
);

   // Next free SRAM address
   logic [addr_w-1:0] addr_cnt;

   // Registered write port
   logic [addr_w-1:0] wr_addr;
   logic [7:0]        wr_data;
   logic              wr_we;
   logic              wr_last;

   //////////////////////////////
   // Pop and write
   //////////////////////////////

   // Take the head whenever there is one and the SRAM is free
   assign pop = ~empty & ~sram_busy;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_we    <= 1'b0;
         wr_last  <= 1'b0;
         done     <= 1'b0;
         addr_cnt <= '0;
      end else begin
         wr_we   <= pop;
         wr_last <= pop & pop_beat.last;
         // One cycle behind the final write
         done    <= wr_last;
         if (pop) begin
            addr_cnt <= pop_beat.last ? '0 : addr_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         wr_addr <= addr_cnt;
         wr_data <= pop_beat.data;
      end
   end

   assign sram_wr = '{addr: wr_addr, data: wr_data, we: wr_we};

endmodule

/* sd_dma_top.sv */
module sd_dma_top
   import sd_dma_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     trig,
   input  logic     miso,
   input  logic     sram_busy,
   output logic     sck,
   output logic     busy,
   output sram_wr_t sram_wr,
   output logic     done
);

   // Reader to FIFO
   logic       push;
   byte_beat_t push_beat;
   logic       full;

   // FIFO to writer
   logic       pop;
   byte_beat_t pop_beat;
   logic       empty;

   spi_block_reader reader_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .trig      (trig),
      .miso      (miso),
      .full      (full),
      .sck       (sck),
      .busy      (busy),
      .push      (push),
      .push_beat (push_beat)
   );

   byte_fifo fifo_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push),
      .push_beat (push_beat),
      .pop       (pop),
      .pop_beat  (pop_beat),
      .full      (full),
      .empty     (empty)
   );

   sram_block_writer writer_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .pop_beat  (pop_beat),
      .empty     (empty),
      .sram_busy (sram_busy),
      .pop       (pop),
      .sram_wr   (sram_wr),
      .done      (done)
   );

endmodule

/* sd_dma_properties.sv */
module sd_dma_properties
   import sd_dma_pkg::*;
(
   input logic     clk,
   input logic     rst_n,
   input logic     push,
   input logic     full,
   input logic     pop,
   input logic     empty,
   input logic     sram_busy,
   input sram_wr_t sram_wr,
   input logic     done,
   input logic     sck,
   input logic     busy
);

   timeunit 1ns;
   timeprecision 1ps;

   //////////////////////////////
   // FIFO access
   //////////////////////////////

   a_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
      else $error("push while the FIFO is full");

   a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
      else $error("pop while the FIFO is empty");

   //////////////////////////////
   // SRAM side and serial clock
   //////////////////////////////

   // Write lands one cycle after its pop
   a_we_busy: assert property (@(posedge clk) disable iff (!rst_n)
                               sram_wr.we |-> !$past(sram_busy))
      else $error("SRAM write for a pop taken while sram_busy was high");

   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else $error("done held high for more than one cycle");

   a_sck_idle: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !sck)
      else $error("sck high while the reader is idle");

endmodule

bind sd_dma_top sd_dma_properties props_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .push      (push),
   .full      (full),
   .pop       (pop),
   .empty     (empty),
   .sram_busy (sram_busy),
   .sram_wr   (sram_wr),
   .done      (done),
   .sck       (sck),
   .busy      (busy)
);

/* tb_sd_dma.sv */
module tb_sd_dma
   import sd_dma_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // Watchdog budget from 8 sck periods plus the gap per byte
   localparam int n_blocks  = 4;
   localparam int byte_clks = 36;
   localparam int wd_cycles = (n_blocks + 2) * total_bytes * byte_clks;

   logic              clk;
   logic              rst_n;
   logic              trig;
   logic              miso;
   logic              sram_busy;
   logic              sck;
   logic              busy;
   sram_wr_t          sram_wr;
   logic              done;

   // Card contents and what the SRAM saw
   logic [7:0]        card_data [total_bytes];
   int                bit_pos;
   logic [addr_w-1:0] wr_addr_q [$];
   logic [7:0]        wr_data_q [$];
   int                done_cnt;
   int                sck_rises;
   logic              busy_prev;
   logic              full_seen;

   // Random source and sram_busy stretches
   logic [31:0]       rng;
   logic              bp_en;
   int                bp_left;

   sd_dma_top dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .trig      (trig),
      .miso      (miso),
      .sram_busy (sram_busy),
      .sck       (sck),
      .busy      (busy),
      .sram_wr   (sram_wr),
      .done      (done)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Mismatch at %0t: %s got 0x%02h expected 0x%02h",
                            $time, name, got, exp));
      end
   endtask

   task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                             input logic [addr_w-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                            $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   //////////////////////////////
   // Card and SRAM models
   //////////////////////////////

   // MSB first and idling high past the CRC
   function automatic logic card_bit(input int pos);
      if (pos >= total_bytes * 8) begin
         return 1'b1;
      end
      return card_data[pos / 8][7 - (pos % 8)];
   endfunction

   always @(negedge sck) begin
      #2;
      bit_pos = bit_pos + 1;
      miso    = card_bit(bit_pos);
   end

   always @(posedge sck) begin
      sck_rises = sck_rises + 1;
   end

   // Write port sampled mid cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (sram_wr.we) begin
            if (busy_prev) begin
               fail_run($sformatf("SRAM write at %0t although sram_busy was high at the pop",
                                  $time));
            end
            wr_addr_q.push_back(sram_wr.addr);
            wr_data_q.push_back(sram_wr.data);
         end
         if (done) begin
            done_cnt = done_cnt + 1;
         end
         if (dut_i.full) begin
            full_seen = 1'b1;
         end
      end
      busy_prev = sram_busy;
   end

   // Alternating busy and free stretches
   always @(posedge clk) begin
      #2;
      if (!bp_en) begin
         sram_busy = 1'b0;
         bp_left   = 0;
      end else if (bp_left == 0) begin
         rng       = xorshift(rng);
         sram_busy = ~sram_busy;
         bp_left   = sram_busy ? 40 + int'(rng % 160) : 4 + int'(rng % 32);
      end else begin
         bp_left = bp_left - 1;
      end
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   task automatic step(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task automatic load_card();
      for (int i = 0; i < total_bytes; i++) begin
         rng          = xorshift(rng);
         card_data[i] = rng[7:0];
      end
      bit_pos   = 0;
      miso      = card_data[0][7];
      wr_addr_q.delete();
      wr_data_q.delete();
      done_cnt  = 0;
      sck_rises = 0;
   endtask

   task automatic start_block();
      step(1);
      trig = 1'b1;
      step(4);
      trig = 1'b0;
   endtask

   // End of block is done seen and busy low
   task automatic wait_block_end();
      do begin
         @(negedge clk);
      end while (done_cnt == 0 || busy);
   endtask

   task automatic check_block();
      check_count("number of SRAM writes", wr_addr_q.size(), block_bytes);
      for (int i = 0; i < block_bytes; i++) begin
         check_addr("sram_wr.addr", wr_addr_q[i], addr_w'(i));
         check_byte("sram_wr.data", wr_data_q[i], card_data[i]);
      end
      check_count("done pulses", done_cnt, 1);
      check_count("sck rising edges", sck_rises, total_bytes * 8);
      check_bit("busy", busy, 1'b0);
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic test_reset();
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         check_bit("sck", sck, 1'b0);
         check_bit("busy", busy, 1'b0);
         check_bit("done", done, 1'b0);
         check_bit("sram_wr.we", sram_wr.we, 1'b0);
      end
      step(1);
   endtask

   task automatic test_single_block();
      load_card();
      start_block();
      wait_block_end();
      step(20);
      check_block();
   endtask

   task automatic test_trig_while_busy();
      load_card();
      start_block();
      step(2000);
      check_bit("busy", busy, 1'b1);
      // Second falling edge mid transfer
      trig = 1'b1;
      step(5);
      trig = 1'b0;
      wait_block_end();
      step(200);
      check_block();
   endtask

   task automatic test_back_pressure();
      load_card();
      full_seen = 1'b0;
      @(negedge clk);
      bp_en = 1'b1;
      start_block();
      wait_block_end();
      bp_en = 1'b0;
      step(20);
      check_block();
      if (!full_seen) begin
         fail_run("The FIFO never filled up during the back-pressure test");
      end
   endtask

   task automatic test_back_to_back();
      load_card();
      start_block();
      wait_block_end();
      step(20);
      check_block();
   endtask

   initial begin
      rng       = 32'd87;
      rst_n     = 1'b0;
      trig      = 1'b1;
      miso      = 1'b1;
      sram_busy = 1'b0;
      bp_en     = 1'b0;
      bp_left   = 0;
      bit_pos   = 0;
      done_cnt  = 0;
      sck_rises = 0;
      busy_prev = 1'b0;
      full_seen = 1'b0;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      test_reset();
      test_single_block();
      test_trig_while_busy();
      test_back_pressure();
      test_back_to_back();
      $display("all tests passed");
      $finish;
   end

   initial begin
      repeat (wd_cycles) @(posedge clk);
      fail_run("The run timed out before all blocks were transferred");
   end

endmodule

/* all.f */
sd_dma_pkg.sv
spi_block_reader.sv
byte_fifo.sv
sram_block_writer.sv
sd_dma_top.sv
sd_dma_properties.sv
tb_sd_dma.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_sd_dma -Mdir obj_dir -f all.f
	./obj_dir/Vtb_sd_dma | tee $(LOG)
	@grep -q "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
